//--- hw/channel_reader.sv
// Channel read engine with outstanding-read limit and data FIFO toward the stream
`timescale 1ns/10ps
`include "kernel_consts.svh"

module channel_reader (
  input  logic                   ap_clk,
  input  logic                   areset,
  chan_ctrl_if.reader            ctrl,
  output logic                   mem_rd_req_valid,
  input  logic                   mem_rd_req_ready,
  output kernel_ctrl_pkg::addr_t mem_rd_req_addr,
  input  logic                   mem_rd_data_valid,
  input  logic [`DATA_W-1:0]     mem_rd_data,
  beat_stream_if.source          out
);

  localparam int DEPTH = `RD_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  kernel_ctrl_pkg::beat_count_t req_left;
  kernel_ctrl_pkg::beat_count_t pop_left;
  kernel_ctrl_pkg::addr_t       req_addr;
  logic [CNT_W-1:0]             reserved;
  logic [CNT_W-1:0]             fifo_cnt;
  logic [PTR_W-1:0]             wr_ptr;
  logic [PTR_W-1:0]             rd_ptr;
  stream_pkg::data_beat_u       fifo_mem [DEPTH];
  logic                         req_fire;
  logic                         pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  //////////////////////////////
  // Request issue
  //////////////////////////////

  // A slot is reserved before the request leaves, so returned data always fits
  assign mem_rd_req_valid = (req_left != '0) && (reserved < CNT_W'(DEPTH));
  assign mem_rd_req_addr  = req_addr;
  assign req_fire         = mem_rd_req_valid & mem_rd_req_ready;
  assign pop              = out.valid & out.ready;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      req_left <= '0;
    end else if (ctrl.start) begin
      req_left <= ctrl.cfg.xfer_beats;
    end else if (req_fire) begin
      req_left <= req_left - 1'b1;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (ctrl.start) begin
      req_addr <= ctrl.rd_base;
    end else if (req_fire) begin
      req_addr <= req_addr + kernel_ctrl_pkg::addr_t'(`DATA_W / 8);
    end
  end

  // Outstanding plus buffered words
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      reserved <= '0;
    end else begin
      reserved <= reserved + CNT_W'(req_fire) - CNT_W'(pop);
    end
  end

  //////////////////////////////
  // Data FIFO
  //////////////////////////////

  always_ff @(posedge ap_clk) begin
    if (mem_rd_data_valid) begin
      fifo_mem[wr_ptr].word <= mem_rd_data;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (mem_rd_data_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      fifo_cnt <= fifo_cnt + CNT_W'(mem_rd_data_valid) - CNT_W'(pop);
    end
  end

  // Words still to hand downstream, for the last flag
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      pop_left <= '0;
    end else if (ctrl.start) begin
      pop_left <= ctrl.cfg.xfer_beats;
    end else if (pop) begin
      pop_left <= pop_left - 1'b1;
    end
  end

  assign out.valid = (fifo_cnt != '0);
  assign out.data  = fifo_mem[rd_ptr];
  assign out.last  = (pop_left == kernel_ctrl_pkg::beat_count_t'(1));

  // Returned data must always find a free entry
  a_fifo_no_overflow : assert property (
    @(posedge ap_clk) disable iff (areset) mem_rd_data_valid |-> (fifo_cnt < CNT_W'(DEPTH))
  ) else $error("Read data arrived with the reader FIFO full");

endmodule : channel_reader

//--- hw/channel_writer.sv
// Channel write engine issuing one write per word and counting responses
`timescale 1ns/10ps
`include "kernel_consts.svh"

module channel_writer (
  input  logic                   ap_clk,
  input  logic                   areset,
  chan_ctrl_if.writer            ctrl,
  beat_stream_if.sink            in,
  output logic                   mem_wr_valid,
  input  logic                   mem_wr_ready,
  output kernel_ctrl_pkg::addr_t mem_wr_addr,
  output logic [`DATA_W-1:0]     mem_wr_data,
  input  logic                   mem_wr_resp
);

  kernel_ctrl_pkg::beat_count_t wr_left;
  kernel_ctrl_pkg::beat_count_t resp_left;
  kernel_ctrl_pkg::addr_t       next_addr;
  kernel_ctrl_pkg::addr_t       wr_addr_r;
  logic [`DATA_W-1:0]           wr_data_r;
  logic                         wr_valid_r;
  logic                         done_r;
  logic                         accept;

  // Take a word only while the run expects more and the request slot frees up
  assign in.ready = (wr_left != '0) && (!wr_valid_r || mem_wr_ready);
  assign accept   = in.valid & in.ready;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wr_left    <= '0;
      wr_valid_r <= 1'b0;
    end else begin
      if (ctrl.start) begin
        wr_left <= ctrl.cfg.xfer_beats;
      end else if (accept) begin
        wr_left <= wr_left - 1'b1;
      end
      if (accept) begin
        wr_valid_r <= 1'b1;
      end else if (mem_wr_ready) begin
        wr_valid_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (ctrl.start) begin
      next_addr <= ctrl.wr_base;
    end else if (accept) begin
      next_addr <= next_addr + kernel_ctrl_pkg::addr_t'(`DATA_W / 8);
    end
    if (accept) begin
      wr_addr_r <= next_addr;
      wr_data_r <= in.data.word;
    end
  end

  // Response counting, done one cycle after the final response
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      resp_left <= '0;
      done_r    <= 1'b0;
    end else begin
      done_r <= mem_wr_resp && (resp_left == kernel_ctrl_pkg::beat_count_t'(1));
      if (ctrl.start) begin
        resp_left <= ctrl.cfg.xfer_beats;
      end else if (mem_wr_resp && resp_left != '0) begin
        resp_left <= resp_left - 1'b1;
      end
    end
  end

  assign mem_wr_valid = wr_valid_r;
  assign mem_wr_addr  = wr_addr_r;
  assign mem_wr_data  = wr_data_r;
  assign ctrl.done    = done_r;

  a_wr_hold : assert property (
    @(posedge ap_clk) disable iff (areset)
    mem_wr_valid && !mem_wr_ready |=>
      mem_wr_valid && $stable(mem_wr_addr) && $stable(mem_wr_data)
  ) else $error("Write request changed before it was accepted");

  // Reader marks last on exactly the final word of the run
  a_last_on_final : assert property (
    @(posedge ap_clk) disable iff (areset)
    accept |-> (in.last == (wr_left == kernel_ctrl_pkg::beat_count_t'(1)))
  ) else $error("Stream last flag does not match the final word");

endmodule : channel_writer

//--- hw/kernel_consts.svh
// Kernel constants for data widths, channel count and reader buffering
`ifndef KERNEL_CONSTS_SVH
`define KERNEL_CONSTS_SVH

// Channel count
`define NUM_CHANNELS 2

// Memory word and adder lane widths
`define DATA_W 64
`define LANE_W 32

// Byte address and transfer length widths
`define ADDR_W 32
`define BEATS_W 16

// Reader FIFO depth, also bounds outstanding reads
`define RD_FIFO_DEPTH 4

`endif

//--- hw/kernel_control.sv
// Kernel control with start edge detection, config capture and done/idle handling
`timescale 1ns/10ps
`include "kernel_consts.svh"

module kernel_control (
  input  logic                                       ap_clk,
  input  logic                                       areset,
  input  logic                                       ap_start,
  input  kernel_ctrl_pkg::beat_count_t               xfer_beats,
  input  stream_pkg::lane_t                          add_constant,
  input  kernel_ctrl_pkg::addr_t [`NUM_CHANNELS-1:0] rd_base,
  input  kernel_ctrl_pkg::addr_t [`NUM_CHANNELS-1:0] wr_base,
  output logic                                       ap_idle,
  output logic                                       ap_done,
  output logic                                       ap_ready,
  chan_ctrl_if.control                               chan [`NUM_CHANNELS]
);

  logic                                       ap_start_r;
  logic                                       ap_idle_r;
  logic                                       ap_done_r;
  logic                                       start_pulse;
  logic                                       chan_start_r;
  logic                                       all_done;
  logic [`NUM_CHANNELS-1:0]                   done_in;
  logic [`NUM_CHANNELS-1:0]                   done_flags;
  kernel_ctrl_pkg::kernel_cfg_t               cfg_r;
  kernel_ctrl_pkg::addr_t [`NUM_CHANNELS-1:0] rd_base_r;
  kernel_ctrl_pkg::addr_t [`NUM_CHANNELS-1:0] wr_base_r;

  //////////////////////////////
  // Start handling
  //////////////////////////////

  // Rising edge of ap_start, only taken while idle
  assign start_pulse = ap_start & ~ap_start_r & ap_idle_r;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_start_r   <= 1'b0;
      chan_start_r <= 1'b0;
    end else begin
      ap_start_r   <= ap_start;
      chan_start_r <= start_pulse;
    end
  end

  // Config registers, stable for the whole run
  always_ff @(posedge ap_clk) begin
    if (start_pulse) begin
      cfg_r.xfer_beats   <= xfer_beats;
      cfg_r.add_constant <= add_constant;
      rd_base_r          <= rd_base;
      wr_base_r          <= wr_base;
    end
  end

  //////////////////////////////
  // Completion
  //////////////////////////////

  // True on the edge where the last channel reports
  assign all_done = &(done_flags | done_in);

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_idle_r  <= 1'b1;
      ap_done_r  <= 1'b0;
      done_flags <= '0;
    end else begin
      ap_done_r  <= all_done;
      done_flags <= all_done ? '0 : (done_flags | done_in);
      if (all_done) begin
        ap_idle_r <= 1'b1;
      end else if (start_pulse) begin
        ap_idle_r <= 1'b0;
      end
    end
  end

  assign ap_idle  = ap_idle_r;
  assign ap_done  = ap_done_r;
  assign ap_ready = ap_done_r;

  for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : g_chan
    assign chan[i].start   = chan_start_r;
    assign chan[i].cfg     = cfg_r;
    assign chan[i].rd_base = rd_base_r[i];
    assign chan[i].wr_base = wr_base_r[i];
    assign done_in[i]      = chan[i].done;
  end

  // Done only ends a run that was busy
  a_done_after_busy : assert property (
    @(posedge ap_clk) disable iff (areset) $rose(ap_done) |-> !$past(ap_idle)
  ) else $error("ap_done rose while the kernel was idle");

endmodule : kernel_control

//--- hw/kernel_ctrl_pkg.sv
// Control and configuration types shared by the kernel control and channels
`include "kernel_consts.svh"

package kernel_ctrl_pkg;

  // Byte address into memory
  typedef logic [`ADDR_W-1:0] addr_t;

  // Number of words in one transfer
  typedef logic [`BEATS_W-1:0] beat_count_t;

  // Run configuration, captured at start and common to all channels
  typedef struct packed {
    beat_count_t        xfer_beats;
    logic [`LANE_W-1:0] add_constant;
  } kernel_cfg_t;

endpackage : kernel_ctrl_pkg

//--- hw/kernel_ifs.sv
// Per-channel control bundle and valid/ready word stream between kernel stages
`timescale 1ns/10ps

interface chan_ctrl_if;
  logic                         start;
  kernel_ctrl_pkg::kernel_cfg_t cfg;
  kernel_ctrl_pkg::addr_t       rd_base;
  kernel_ctrl_pkg::addr_t       wr_base;
  logic                         done;

  modport control (
    output start, cfg, rd_base, wr_base,
    input  done
  );

  modport reader (
    input start, cfg, rd_base
  );

  // Adder only needs the constant from cfg
  modport adder (
    input cfg
  );

  modport writer (
    input  start, cfg, wr_base,
    output done
  );
endinterface : chan_ctrl_if

// A word moves when valid and ready are both high
interface beat_stream_if;
  logic                   valid;
  logic                   ready;
  logic                   last;
  stream_pkg::data_beat_u data;

  modport source (output valid, last, data, input ready);
  modport sink   (input valid, last, data, output ready);
endinterface : beat_stream_if

//--- hw/lane_adder.sv
// Pipelined adder that adds the run constant to every lane of each word
`timescale 1ns/10ps
`include "kernel_consts.svh"

module lane_adder (
  input  logic          ap_clk,
  input  logic          areset,
  chan_ctrl_if.adder    ctrl,
  beat_stream_if.sink   in,
  beat_stream_if.source out
);

  localparam int LANES = `DATA_W / `LANE_W;

  logic                   out_valid_r;
  logic                   out_last_r;
  stream_pkg::data_beat_u sum_r;

  // Stage frees up when empty or when its word leaves this cycle
  assign in.ready = ~out_valid_r | out.ready;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      out_valid_r <= 1'b0;
    end else if (in.ready) begin
      out_valid_r <= in.valid;
    end
  end

  // Lane sums wrap modulo 2^LANE_W
  always_ff @(posedge ap_clk) begin
    if (in.valid && in.ready) begin
      for (int i = 0; i < LANES; i++) begin
        sum_r.lanes[i] <= in.data.lanes[i] + ctrl.cfg.add_constant;
      end
      out_last_r <= in.last;
    end
  end

  assign out.valid = out_valid_r;
  assign out.data  = sum_r;
  assign out.last  = out_last_r;

endmodule : lane_adder

//--- hw/stream_pkg.sv
// Data-path types for memory words and their lane view
`include "kernel_consts.svh"

package stream_pkg;

  // One adder lane
  typedef logic [`LANE_W-1:0] lane_t;

  // Memory word, seen either as a raw word or as lanes
  // Lane 0 sits in the low bits of the word
  typedef union packed {
    logic [`DATA_W-1:0]                word;
    lane_t [`DATA_W/`LANE_W-1:0]       lanes;
  } data_beat_u;

endpackage : stream_pkg

//--- hw/vadd_kernel_top.sv
// Multi-channel vector-add kernel, control block plus reader, adder and writer per channel
`timescale 1ns/10ps
`include "kernel_consts.svh"

module vadd_kernel_top (
  input  logic                                          ap_clk,
  input  logic                                          areset,
  input  logic                                          ap_start,
  output logic                                          ap_idle,
  output logic                                          ap_done,
  output logic                                          ap_ready,
  input  kernel_ctrl_pkg::beat_count_t                  xfer_beats,
  input  stream_pkg::lane_t                             add_constant,
  input  kernel_ctrl_pkg::addr_t [`NUM_CHANNELS-1:0]    rd_base,
  input  kernel_ctrl_pkg::addr_t [`NUM_CHANNELS-1:0]    wr_base,
  // Memory read side
  output logic [`NUM_CHANNELS-1:0]                      mem_rd_req_valid,
  input  logic [`NUM_CHANNELS-1:0]                      mem_rd_req_ready,
  output kernel_ctrl_pkg::addr_t [`NUM_CHANNELS-1:0]    mem_rd_req_addr,
  input  logic [`NUM_CHANNELS-1:0]                      mem_rd_data_valid,
  input  logic [`NUM_CHANNELS-1:0][`DATA_W-1:0]         mem_rd_data,
  // Memory write side
  output logic [`NUM_CHANNELS-1:0]                      mem_wr_valid,
  input  logic [`NUM_CHANNELS-1:0]                      mem_wr_ready,
  output kernel_ctrl_pkg::addr_t [`NUM_CHANNELS-1:0]    mem_wr_addr,
  output logic [`NUM_CHANNELS-1:0][`DATA_W-1:0]         mem_wr_data,
  input  logic [`NUM_CHANNELS-1:0]                      mem_wr_resp
);

  chan_ctrl_if chan_ctrl [`NUM_CHANNELS] ();

  kernel_control u_kernel_control (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .ap_start     (ap_start),
    .xfer_beats   (xfer_beats),
    .add_constant (add_constant),
    .rd_base      (rd_base),
    .wr_base      (wr_base),
    .ap_idle      (ap_idle),
    .ap_done      (ap_done),
    .ap_ready     (ap_ready),
    .chan         (chan_ctrl)
  );

  //////////////////////////////
  // One data path per channel
  //////////////////////////////

  for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : g_chan
    beat_stream_if rd_stream ();
    beat_stream_if add_stream ();

    channel_reader u_channel_reader (
      .ap_clk            (ap_clk),
      .areset            (areset),
      .ctrl              (chan_ctrl[i]),
      .mem_rd_req_valid  (mem_rd_req_valid[i]),
      .mem_rd_req_ready  (mem_rd_req_ready[i]),
      .mem_rd_req_addr   (mem_rd_req_addr[i]),
      .mem_rd_data_valid (mem_rd_data_valid[i]),
      .mem_rd_data       (mem_rd_data[i]),
      .out               (rd_stream)
    );

    lane_adder u_lane_adder (
      .ap_clk (ap_clk),
      .areset (areset),
      .ctrl   (chan_ctrl[i]),
      .in     (rd_stream),
      .out    (add_stream)
    );

    channel_writer u_channel_writer (
      .ap_clk       (ap_clk),
      .areset       (areset),
      .ctrl         (chan_ctrl[i]),
      .in           (add_stream),
      .mem_wr_valid (mem_wr_valid[i]),
      .mem_wr_ready (mem_wr_ready[i]),
      .mem_wr_addr  (mem_wr_addr[i]),
      .mem_wr_data  (mem_wr_data[i]),
      .mem_wr_resp  (mem_wr_resp[i])
    );
  end

endmodule : vadd_kernel_top

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vector-add kernel testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_vadd_kernel -Mdir obj_dir -o tb_vadd_kernel -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_vadd_kernel > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- testbench/tb_memory.sv
// Memory model with random back-pressure, in-order read returns and write recording
`timescale 1ns/10ps
`include "kernel_consts.svh"

module tb_memory #(
  parameter int WORDS = 1024
) (
  input  logic                                  ap_clk,
  input  logic                                  hold_rd,
  input  logic [`NUM_CHANNELS-1:0]              mem_rd_req_valid,
  output logic [`NUM_CHANNELS-1:0]              mem_rd_req_ready,
  input  logic [`NUM_CHANNELS-1:0][`ADDR_W-1:0] mem_rd_req_addr,
  output logic [`NUM_CHANNELS-1:0]              mem_rd_data_valid,
  output logic [`NUM_CHANNELS-1:0][`DATA_W-1:0] mem_rd_data,
  input  logic [`NUM_CHANNELS-1:0]              mem_wr_valid,
  output logic [`NUM_CHANNELS-1:0]              mem_wr_ready,
  input  logic [`NUM_CHANNELS-1:0][`ADDR_W-1:0] mem_wr_addr,
  input  logic [`NUM_CHANNELS-1:0][`DATA_W-1:0] mem_wr_data,
  output logic [`NUM_CHANNELS-1:0]              mem_wr_resp
);

  localparam int NCH   = `NUM_CHANNELS;
  localparam int QLEN  = 32;
  localparam int IDX_W = $clog2(WORDS);

  logic [`DATA_W-1:0]          mem [WORDS];
  int                          wr_total [NCH];
  int                          max_pending [NCH];
  logic [IDX_W-1:0]            rd_q [NCH][QLEN];
  int                          q_head [NCH];
  int                          q_tail [NCH];
  int                          pend;
  logic [31:0]                 lfsr = 32'd4;
  logic                        hold_s;
  logic [NCH-1:0]              rd_fire;
  logic [NCH-1:0]              wr_fire;
  logic [NCH-1:0][`ADDR_W-1:0] rd_addr_s;
  logic [NCH-1:0][`ADDR_W-1:0] wr_addr_s;
  logic [NCH-1:0][`DATA_W-1:0] wr_data_s;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  initial begin
    // Fill mixes the word index into random data
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = {rand_bits(32), rand_bits(32) ^ 32'(i)};
    end
    mem_rd_req_ready  = '0;
    mem_rd_data_valid = '0;
    mem_rd_data       = '0;
    mem_wr_ready      = '0;
    mem_wr_resp       = '0;
    for (int ch = 0; ch < NCH; ch++) begin
      wr_total[ch]    = 0;
      max_pending[ch] = 0;
      q_head[ch]      = 0;
      q_tail[ch]      = 0;
    end
    forever begin
      // Handshakes seen here complete on the next rising edge
      @(negedge ap_clk);
      hold_s    = hold_rd;
      rd_fire   = mem_rd_req_valid & mem_rd_req_ready;
      wr_fire   = mem_wr_valid & mem_wr_ready;
      rd_addr_s = mem_rd_req_addr;
      wr_addr_s = mem_wr_addr;
      wr_data_s = mem_wr_data;
      @(posedge ap_clk);
      #1;
      for (int ch = 0; ch < NCH; ch++) begin
        mem_rd_data_valid[ch] = 1'b0;
        mem_wr_resp[ch]       = 1'b0;
        // Oldest request first, never in the cycle it was taken
        if (!hold_s && q_tail[ch] != q_head[ch] && rand_bits(1) == 32'd1) begin
          mem_rd_data_valid[ch] = 1'b1;
          mem_rd_data[ch]       = mem[rd_q[ch][q_head[ch] % QLEN]];
          q_head[ch]++;
        end
        if (rd_fire[ch]) begin
          rd_q[ch][q_tail[ch] % QLEN] = rd_addr_s[ch][IDX_W+2:3];
          q_tail[ch]++;
        end
        if (wr_fire[ch]) begin
          mem[wr_addr_s[ch][IDX_W+2:3]] = wr_data_s[ch];
          mem_wr_resp[ch] = 1'b1;
          wr_total[ch]++;
        end
        // The word on the bus stays outstanding until the next edge
        pend = q_tail[ch] - q_head[ch] + int'(mem_rd_data_valid[ch]);
        if (pend > max_pending[ch]) begin
          max_pending[ch] = pend;
        end
        mem_rd_req_ready[ch] = (rand_bits(2) != 32'd0);
        mem_wr_ready[ch]     = (rand_bits(2) != 32'd0);
      end
    end
  end

endmodule : tb_memory

//--- testbench/tb_vadd_kernel.sv
// Testbench for the vector-add kernel with random runs checked against a lane-add model
`timescale 1ns/10ps
`include "kernel_consts.svh"

module tb_vadd_kernel;

  localparam int NCH        = `NUM_CHANNELS;
  localparam int MEM_WORDS  = 1024;
  localparam int NUM_RUNS   = 6;
  localparam int DONE_LIMIT = 3000;

  logic                        ap_clk = 1'b0;
  logic                        areset;
  logic                        ap_start;
  logic                        ap_idle;
  logic                        ap_done;
  logic                        ap_ready;
  logic [`BEATS_W-1:0]         xfer_beats;
  logic [`LANE_W-1:0]          add_constant;
  logic [NCH-1:0][`ADDR_W-1:0] rd_base;
  logic [NCH-1:0][`ADDR_W-1:0] wr_base;
  logic                        hold_rd;
  logic [NCH-1:0]              mem_rd_req_valid;
  logic [NCH-1:0]              mem_rd_req_ready;
  logic [NCH-1:0][`ADDR_W-1:0] mem_rd_req_addr;
  logic [NCH-1:0]              mem_rd_data_valid;
  logic [NCH-1:0][`DATA_W-1:0] mem_rd_data;
  logic [NCH-1:0]              mem_wr_valid;
  logic [NCH-1:0]              mem_wr_ready;
  logic [NCH-1:0][`ADDR_W-1:0] mem_wr_addr;
  logic [NCH-1:0][`DATA_W-1:0] mem_wr_data;
  logic [NCH-1:0]              mem_wr_resp;
  logic [31:0]                 lfsr = 32'd4;
  logic                        timed_out = 1'b0;
  int                          value_errors = 0;
  int                          other_errors = 0;

  always #5 ap_clk = ~ap_clk;

  vadd_kernel_top u_vadd_kernel_top (.*);

  tb_memory #(.WORDS(MEM_WORDS)) u_tb_memory (
    .ap_clk            (ap_clk),
    .hold_rd           (hold_rd),
    .mem_rd_req_valid  (mem_rd_req_valid),
    .mem_rd_req_ready  (mem_rd_req_ready),
    .mem_rd_req_addr   (mem_rd_req_addr),
    .mem_rd_data_valid (mem_rd_data_valid),
    .mem_rd_data       (mem_rd_data),
    .mem_wr_valid      (mem_wr_valid),
    .mem_wr_ready      (mem_wr_ready),
    .mem_wr_addr       (mem_wr_addr),
    .mem_wr_data       (mem_wr_data),
    .mem_wr_resp       (mem_wr_resp)
  );

  //////////////////////////////
  // Helpers and model
  //////////////////////////////

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Each lane plus the constant modulo 2^32 with lane 0 in the low bits
  function automatic logic [`DATA_W-1:0] expected_word(input logic [`DATA_W-1:0] src,
                                                       input logic [`LANE_W-1:0] c);
    logic [`DATA_W-1:0] w;
    for (int l = 0; l < `DATA_W / `LANE_W; l++) begin
      w[l*`LANE_W +: `LANE_W] = src[l*`LANE_W +: `LANE_W] + c;
    end
    return w;
  endfunction

  task automatic tick();
    @(posedge ap_clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    value_errors++;
    $display("CHECK FAILED at %0t ns: %s expected 0x%0h, actual 0x%0h",
             $time, name, expected, actual);
  endtask

  task automatic report_problem(input string msg);
    other_errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  //////////////////////////////
  // One kernel run
  //////////////////////////////

  task automatic run_kernel(input logic hold, input logic restart);
    int                  rd_word [NCH];
    int                  wr_word [NCH];
    int                  wr_before [NCH];
    int                  resp_cnt [NCH];
    int                  resp_cyc;
    int                  cyc;
    logic                all_resp;
    logic                exp_done;
    logic                seen_done;
    logic [`BEATS_W-1:0] run_beats;
    logic [`LANE_W-1:0]  run_const;
    logic [`DATA_W-1:0]  exp_w;
    logic [`DATA_W-1:0]  act_w;
    tick();
    // A held run needs enough words to fill the reader
    run_beats    = hold ? `BEATS_W'(12 + rand_bits(2)) : `BEATS_W'(rand_bits(4) + 1);
    run_const    = rand_bits(32);
    xfer_beats   = run_beats;
    add_constant = run_const;
    for (int ch = 0; ch < NCH; ch++) begin
      rd_word[ch]   = int'(rand_bits(8));
      wr_word[ch]   = MEM_WORDS / 2 + ch * (MEM_WORDS / 2 / NCH) + int'(rand_bits(7));
      rd_base[ch]   = `ADDR_W'(rd_word[ch] * 8);
      wr_base[ch]   = `ADDR_W'(wr_word[ch] * 8);
      wr_before[ch] = u_tb_memory.wr_total[ch];
      resp_cnt[ch]  = 0;
    end
    hold_rd   = hold;
    ap_start  = 1'b1;
    cyc       = 0;
    resp_cyc  = -1;
    seen_done = 1'b0;
    while (!seen_done && cyc < DONE_LIMIT) begin
      tick();
      // Second rising edge while busy
      ap_start = (restart && cyc >= 2);
      if (cyc == 0) begin
        // Run settings are held in the kernel from the start edge on
        xfer_beats   = ~run_beats;
        add_constant = ~run_const;
        rd_base      = ~rd_base;
        wr_base      = ~wr_base;
      end
      if (cyc >= 40) begin
        hold_rd = 1'b0;
      end
      @(negedge ap_clk);
      all_resp = 1'b1;
      for (int ch = 0; ch < NCH; ch++) begin
        if (mem_wr_resp[ch] === 1'b1) begin
          resp_cnt[ch]++;
        end
        if (resp_cnt[ch] < int'(run_beats)) begin
          all_resp = 1'b0;
        end
      end
      if (all_resp && resp_cyc < 0) begin
        resp_cyc = cyc;
      end
      // ap_done two cycles after the final write response
      exp_done = (resp_cyc >= 0) && (cyc == resp_cyc + 2);
      if (ap_done !== exp_done) begin
        report_mismatch("ap_done", 64'(exp_done), 64'(ap_done));
      end
      if (ap_ready !== exp_done) begin
        report_mismatch("ap_ready", 64'(exp_done), 64'(ap_ready));
      end
      if (exp_done) begin
        seen_done = 1'b1;
        if (ap_idle !== 1'b1) begin
          report_mismatch("ap_idle", 64'd1, 64'(ap_idle));
        end
      end else if (ap_idle !== 1'b0) begin
        report_mismatch("ap_idle", 64'd0, 64'(ap_idle));
      end
      cyc++;
    end
    if (!seen_done) begin
      report_problem("Timed out waiting for the write responses and ap_done");
      timed_out = 1'b1;
    end else begin
      @(negedge ap_clk);
      if (ap_done !== 1'b0 || ap_ready !== 1'b0) begin
        report_problem("ap_done or ap_ready stayed high for more than one cycle");
      end
      if (restart) begin
        // Kernel stays idle while ap_start is still high
        repeat (20) begin
          @(negedge ap_clk);
          if (ap_idle !== 1'b1 || mem_rd_req_valid !== '0) begin
            report_problem("Kernel started again while ap_start was held high");
          end
        end
        tick();
        ap_start = 1'b0;
      end
      for (int ch = 0; ch < NCH; ch++) begin
        if (u_tb_memory.wr_total[ch] - wr_before[ch] != int'(run_beats)) begin
          report_mismatch($sformatf("write count ch%0d", ch), 64'(run_beats),
                          64'(u_tb_memory.wr_total[ch] - wr_before[ch]));
        end
        for (int i = 0; i < int'(run_beats); i++) begin
          exp_w = expected_word(u_tb_memory.mem[rd_word[ch] + i], run_const);
          act_w = u_tb_memory.mem[wr_word[ch] + i];
          if (act_w !== exp_w) begin
            report_mismatch($sformatf("mem_wr_data ch%0d word %0d", ch, i), exp_w, act_w);
          end
        end
      end
    end
  endtask

  initial begin
    areset       = 1'b1;
    ap_start     = 1'b0;
    xfer_beats   = '0;
    add_constant = '0;
    rd_base      = '0;
    wr_base      = '0;
    hold_rd      = 1'b0;
    repeat (5) @(posedge ap_clk);
    #1;
    areset = 1'b0;
    @(negedge ap_clk);
    if (ap_idle !== 1'b1) begin
      report_mismatch("ap_idle", 64'd1, 64'(ap_idle));
    end
    if (ap_done !== 1'b0 || ap_ready !== 1'b0) begin
      report_problem("ap_done or ap_ready high after reset");
    end
    if (mem_rd_req_valid !== '0 || mem_wr_valid !== '0) begin
      report_problem("Memory request valid high after reset");
    end
    // Run 2 holds read data back and run 4 re-raises ap_start while busy
    for (int r = 0; r < NUM_RUNS && !timed_out; r++) begin
      run_kernel(r == 2, r == 4);
    end
    for (int ch = 0; ch < NCH; ch++) begin
      if (u_tb_memory.max_pending[ch] != `RD_FIFO_DEPTH) begin
        report_mismatch($sformatf("max outstanding reads ch%0d", ch), 64'(`RD_FIFO_DEPTH),
                        64'(u_tb_memory.max_pending[ch]));
      end
    end
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_vadd_kernel

//--- vlog.f
+incdir+hw
hw/kernel_ctrl_pkg.sv
hw/stream_pkg.sv
hw/kernel_ifs.sv
hw/kernel_control.sv
hw/channel_reader.sv
hw/lane_adder.sv
hw/channel_writer.sv
hw/vadd_kernel_top.sv
testbench/tb_memory.sv
testbench/tb_vadd_kernel.sv
